//--- verilog/mmu_pkg.sv
package mmu_pkg;

	// address format
	localparam int va_w = 64;
	localparam int pa_w = 64;
	localparam int page_offset_w = 12;
	localparam int index_w = 9;
	localparam int tlb_tag_w = 43;

	// Sv39-style page table
	localparam int vpn_field_w = 9;
	localparam int walk_levels = 3;
	localparam int ppn_lsb = 10;
	localparam int ppn_msb = pa_w - page_offset_w + ppn_lsb - 1; // top ppn bit that fits a pa

	// memory bus
	localparam int bus_data_w = 64;
	localparam int bus_tag_w = 13;

	// addr_available codes
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_waiting = 2'd1;
	localparam logic [1:0] st_hit = 2'd2;
	localparam logic [1:0] st_miss = 2'd3;

	typedef struct packed {
		logic valid;
		logic lru; // set = next victim
	} tlb_state_t;

	typedef struct packed {
		logic [tlb_tag_w-1:0] tag;
		logic [63:0] pte;
		tlb_state_t state;
	} tlb_entry_t;

	// miss handed from buffer to walker
	typedef struct packed {
		logic [va_w-1:0] vaddr;
		logic [pa_w-1:0] root;
	} walk_req_t;

	// single table read from walker to bus side
	typedef struct packed {
		logic [pa_w-1:0] addr;
		logic [bus_tag_w-1:0] tag;
	} mem_read_t;

endpackage

//--- verilog/tlb.sv
`timescale 1ns/1ns

module tlb (
	input logic clk,
	input logic reset,
	input logic [mmu_pkg::va_w-1:0] v_addr,
	input logic rd_signal,
	input logic [mmu_pkg::pa_w-1:0] ptbr,
	input logic walk_done,
	input logic [63:0] walk_pte,
	output logic [mmu_pkg::pa_w-1:0] p_addr,
	output logic [1:0] addr_available,
	output logic walk_start,
	output mmu_pkg::walk_req_t walk_req
);

	mmu_pkg::tlb_entry_t ways [2][2**mmu_pkg::index_w];

	logic [mmu_pkg::index_w-1:0] index;
	logic [mmu_pkg::tlb_tag_w-1:0] tag;
	mmu_pkg::tlb_entry_t e0;
	mmu_pkg::tlb_entry_t e1;
	logic hit0;
	logic hit1;
	logic hit;
	logic hit_way;
	logic [63:0] hit_pte;
	logic victim;

	logic waiting; // walk outstanding
	logic victim_q;
	logic [mmu_pkg::index_w-1:0] fill_index;
	mmu_pkg::tlb_entry_t fill_entry;

	assign index = v_addr[mmu_pkg::page_offset_w +: mmu_pkg::index_w];
	assign tag = v_addr[mmu_pkg::va_w-1 -: mmu_pkg::tlb_tag_w];

	assign e0 = ways[0][index];
	assign e1 = ways[1][index];

	assign hit0 = e0.state.valid && (e0.tag == tag);
	assign hit1 = e1.state.valid && (e1.tag == tag);
	assign hit = hit0 || hit1;
	assign hit_way = !hit0; // way 0 wins if both match
	assign hit_pte = hit0 ? e0.pte : e1.pte;

	// invalid way first, then the one marked lru
	always_comb begin
		if (!e0.state.valid)
			victim = 1'b0;
		else if (!e1.state.valid)
			victim = 1'b1;
		else
			victim = !e0.state.lru;
	end

	always_comb begin
		p_addr = '0;
		if (!rd_signal) begin
			addr_available = mmu_pkg::st_idle;
		end else if (waiting) begin
			addr_available = mmu_pkg::st_waiting;
		end else if (hit) begin
			addr_available = mmu_pkg::st_hit;
			p_addr = {hit_pte[mmu_pkg::ppn_msb:mmu_pkg::ppn_lsb],
				v_addr[mmu_pkg::page_offset_w-1:0]};
		end else begin
			addr_available = mmu_pkg::st_miss;
		end
	end

	// fill uses the address held for the walk
	assign fill_index = walk_req.vaddr[mmu_pkg::page_offset_w +: mmu_pkg::index_w];

	always_comb begin
		fill_entry.tag = walk_req.vaddr[mmu_pkg::va_w-1 -: mmu_pkg::tlb_tag_w];
		fill_entry.pte = walk_pte;
		fill_entry.state.valid = 1'b1;
		fill_entry.state.lru = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
			walk_start <= 1'b0;
			for (int s = 0; s < 2**mmu_pkg::index_w; s++) begin
				ways[0][s].state <= '0;
				ways[1][s].state <= '0;
			end
		end else begin
			walk_start <= 1'b0;
			if (waiting) begin
				if (walk_done) begin
					ways[victim_q][fill_index] <= fill_entry;
					ways[!victim_q][fill_index].state.lru <= 1'b1;
					waiting <= 1'b0;
				end
			end else if (rd_signal) begin
				if (hit) begin
					ways[hit_way][index].state.lru <= 1'b0;
					ways[!hit_way][index].state.lru <= 1'b1;
				end else begin
					waiting <= 1'b1;
					walk_start <= 1'b1;
					victim_q <= victim;
				end
			end
		end
	end

	// walk request payload, captured in the miss cycle
	always_ff @(posedge clk) begin
		if (rd_signal && !waiting && !hit) begin
			walk_req.vaddr <= v_addr;
			walk_req.root <= ptbr;
		end
	end

endmodule

//--- verilog/page_walker.sv
`timescale 1ns/1ns

module page_walker (
	input logic clk,
	input logic reset,
	input logic walk_start,
	input mmu_pkg::walk_req_t walk_req,
	input logic rd_done,
	input logic [mmu_pkg::bus_data_w-1:0] rd_data,
	output logic rd_start,
	output mmu_pkg::mem_read_t rd_req,
	output logic walk_done,
	output logic [63:0] walk_pte
);

	typedef enum logic [1:0] {
		w_idle,
		w_issue,
		w_wait
	} walk_state_t;

	walk_state_t state;
	logic [1:0] level;
	logic [mmu_pkg::va_w-1:0] vaddr_q;
	logic [mmu_pkg::pa_w-1:0] base_q; // table base for current level
	logic [mmu_pkg::bus_tag_w-1:0] tag_ctr;
	logic [mmu_pkg::pa_w-1:0] next_base;

	// base + 8 * vpn field of the given level
	function automatic logic [mmu_pkg::pa_w-1:0] entry_addr(
		input logic [mmu_pkg::pa_w-1:0] base,
		input logic [mmu_pkg::va_w-1:0] vaddr,
		input logic [1:0] lvl
	);
		logic [mmu_pkg::vpn_field_w-1:0] field;
		logic [mmu_pkg::pa_w-1:0] offset;
		field = vaddr[mmu_pkg::page_offset_w + lvl * mmu_pkg::vpn_field_w +:
			mmu_pkg::vpn_field_w];
		offset = {{(mmu_pkg::pa_w - mmu_pkg::vpn_field_w - 3){1'b0}}, field, 3'b000};
		return base + offset;
	endfunction

	assign next_base = {rd_data[mmu_pkg::ppn_msb:mmu_pkg::ppn_lsb],
		{mmu_pkg::page_offset_w{1'b0}}};

	assign rd_start = (state == w_issue);
	assign rd_req.addr = entry_addr(base_q, vaddr_q, level);
	assign rd_req.tag = tag_ctr;

	// leaf entry goes out with the last response
	assign walk_done = (state == w_wait) && rd_done && (level == 2'd0);
	assign walk_pte = rd_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= w_idle;
			level <= '0;
			tag_ctr <= '0;
		end else begin
			case (state)
				w_idle: begin
					if (walk_start) begin
						state <= w_issue;
						level <= 2'(mmu_pkg::walk_levels - 1);
					end
				end
				w_issue: begin
					state <= w_wait;
					tag_ctr <= tag_ctr + 1'b1; // fresh tag per read
				end
				w_wait: begin
					if (rd_done) begin
						if (level == 2'd0) begin
							state <= w_idle;
						end else begin
							state <= w_issue;
							level <= level - 1'b1;
						end
					end
				end
				default: state <= w_idle;
			endcase
		end
	end

	// address and base registers
	always_ff @(posedge clk) begin
		if (state == w_idle && walk_start) begin
			vaddr_q <= walk_req.vaddr;
			base_q <= walk_req.root;
		end else if (state == w_wait && rd_done) begin
			base_q <= next_base; // descend one level
		end
	end

endmodule

//--- verilog/bus_master.sv
`timescale 1ns/1ns

module bus_master (
	input logic clk,
	input logic reset,
	input logic rd_start,
	input mmu_pkg::mem_read_t rd_req,
	input logic abtr_grant,
	input logic bus_reqack,
	input logic bus_respcyc,
	input logic [mmu_pkg::bus_data_w-1:0] bus_resp,
	input logic [mmu_pkg::bus_tag_w-1:0] bus_resptag,
	output logic rd_done,
	output logic [mmu_pkg::bus_data_w-1:0] rd_data,
	output logic abtr_reqcyc,
	output logic bus_reqcyc,
	output logic [mmu_pkg::bus_data_w-1:0] bus_req,
	output logic [mmu_pkg::bus_tag_w-1:0] bus_reqtag,
	output logic bus_respack,
	output logic bus_busy
);

	typedef enum logic [1:0] {
		ph_arb,
		ph_req,
		ph_resp,
		ph_done
	} phase_t;

	phase_t phase;
	mmu_pkg::mem_read_t req_q; // outstanding read
	logic tag_match;

	// other tags belong to someone else
	assign tag_match = (phase == ph_resp) && bus_respcyc && (bus_resptag == req_q.tag);

	assign abtr_reqcyc = (phase == ph_arb);
	assign bus_reqcyc = (phase == ph_req);
	assign bus_req = req_q.addr;
	assign bus_reqtag = req_q.tag;
	assign bus_respack = tag_match;
	assign rd_done = tag_match;
	assign rd_data = bus_resp;
	assign bus_busy = rd_start || (phase != ph_done);

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= ph_done; // resting phase
		end else begin
			case (phase)
				ph_done: if (rd_start) phase <= ph_arb;
				ph_arb: if (abtr_grant) phase <= ph_req;
				ph_req: if (bus_reqack) phase <= ph_resp;
				ph_resp: if (tag_match) phase <= ph_done;
				default: phase <= ph_done;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == ph_done && rd_start)
			req_q <= rd_req;
	end

endmodule

//--- verilog/mmu_top.sv
`timescale 1ns/1ns

module mmu_top (
	input logic clk,
	input logic reset,
	input logic [mmu_pkg::va_w-1:0] v_addr,
	input logic rd_signal,
	input logic [mmu_pkg::pa_w-1:0] ptbr,
	input logic abtr_grant,
	input logic bus_reqack,
	input logic bus_respcyc,
	input logic [mmu_pkg::bus_data_w-1:0] bus_resp,
	input logic [mmu_pkg::bus_tag_w-1:0] bus_resptag,
	output logic [mmu_pkg::pa_w-1:0] p_addr,
	output logic [1:0] addr_available,
	output logic abtr_reqcyc,
	output logic bus_reqcyc,
	output logic [mmu_pkg::bus_data_w-1:0] bus_req,
	output logic [mmu_pkg::bus_tag_w-1:0] bus_reqtag,
	output logic bus_respack,
	output logic bus_busy
);

	logic walk_start;
	mmu_pkg::walk_req_t walk_req;
	logic walk_done;
	logic [63:0] walk_pte;

	logic rd_start;
	mmu_pkg::mem_read_t rd_req;
	logic rd_done;
	logic [mmu_pkg::bus_data_w-1:0] rd_data;

	tlb tlb0 (
		.clk(clk),
		.reset(reset),
		.v_addr(v_addr),
		.rd_signal(rd_signal),
		.ptbr(ptbr),
		.walk_done(walk_done),
		.walk_pte(walk_pte),
		.p_addr(p_addr),
		.addr_available(addr_available),
		.walk_start(walk_start),
		.walk_req(walk_req)
	);

	page_walker walker0 (
		.clk(clk),
		.reset(reset),
		.walk_start(walk_start),
		.walk_req(walk_req),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.rd_start(rd_start),
		.rd_req(rd_req),
		.walk_done(walk_done),
		.walk_pte(walk_pte)
	);

	bus_master bus0 (
		.clk(clk),
		.reset(reset),
		.rd_start(rd_start),
		.rd_req(rd_req),
		.abtr_grant(abtr_grant),
		.bus_reqack(bus_reqack),
		.bus_respcyc(bus_respcyc),
		.bus_resp(bus_resp),
		.bus_resptag(bus_resptag),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.abtr_reqcyc(abtr_reqcyc),
		.bus_reqcyc(bus_reqcyc),
		.bus_req(bus_req),
		.bus_reqtag(bus_reqtag),
		.bus_respack(bus_respack),
		.bus_busy(bus_busy)
	);

endmodule

//--- test/mem_model.sv
`timescale 1ns/1ns

module mem_model (
	input logic clk,
	input logic reset,
	input logic abtr_reqcyc,
	input logic bus_reqcyc,
	input logic [63:0] bus_req,
	input logic [12:0] bus_reqtag,
	output logic abtr_grant,
	output logic bus_reqack,
	output logic bus_respcyc,
	output logic [63:0] bus_resp,
	output logic [12:0] bus_resptag
);

	logic [63:0] word_addr [32];
	logic [63:0] word_data [32];
	int n_words = 0;
	logic [63:0] read_addr [64]; // wraps
	int read_count = 0;

	logic [31:0] lfsr_state = 32'hd5e0cd58;
	int grant_wait = 0;
	int ack_wait = 0;
	int resp_wait = 0;
	logic pending = 1'b0;
	logic [63:0] pend_addr;
	logic [12:0] pend_tag;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic logic [63:0] word_at(input logic [63:0] addr);
		logic [63:0] w;
		w = {addr[31:0], addr[63:32]} ^ 64'h5a5a_c3c3_0ff0_9669; // unmapped words
		for (int i = 0; i < n_words; i++)
			if (word_addr[i] == addr)
				w = word_data[i];
		return w;
	endfunction

	initial begin
		abtr_grant = 1'b0;
		bus_reqack = 1'b0;
		bus_respcyc = 1'b0;
		bus_resp = '0;
		bus_resptag = '0;
	end

	always @(negedge clk) begin
		abtr_grant <= 1'b0;
		bus_reqack <= 1'b0;
		bus_respcyc <= 1'b0;
		if (reset) begin
			pending = 1'b0;
		end else begin
			if (abtr_reqcyc) begin
				if (grant_wait == 0) begin
					abtr_grant <= 1'b1;
					grant_wait = take_bits(2);
				end else
					grant_wait--;
			end
			if (bus_reqcyc) begin
				if (ack_wait == 0) begin
					bus_reqack <= 1'b1;
					ack_wait = take_bits(2);
					read_addr[read_count % 64] = bus_req;
					read_count++;
					pend_addr = bus_req;
					pend_tag = bus_reqtag;
					pending = 1'b1;
					resp_wait = take_bits(3);
				end else
					ack_wait--;
			end else if (pending) begin
				if (resp_wait == 0) begin
					bus_respcyc <= 1'b1;
					bus_resp <= word_at(pend_addr);
					bus_resptag <= pend_tag;
					pending = 1'b0;
				end else begin
					resp_wait--;
					if (take_bits(1) == 1) begin // decoy, foreign tag
						bus_respcyc <= 1'b1;
						bus_resp <= ~word_at(pend_addr);
						bus_resptag <= pend_tag ^ 13'h0a5a;
					end
				end
			end
		end
	end

endmodule

//--- test/mmu_tb.sv
`timescale 1ns/1ns

module mmu_tb;

	logic clk;
	logic reset;
	logic [63:0] v_addr;
	logic rd_signal;
	logic [63:0] ptbr;
	logic abtr_grant;
	logic bus_reqack;
	logic bus_respcyc;
	logic [63:0] bus_resp;
	logic [12:0] bus_resptag;
	logic [63:0] p_addr;
	logic [1:0] addr_available;
	logic abtr_reqcyc;
	logic bus_reqcyc;
	logic [63:0] bus_req;
	logic [12:0] bus_reqtag;
	logic bus_respack;
	logic bus_busy;

	int errors = 0;
	int checks = 0;
	int n_req = 0;
	logic loaded = 1'b0;
	logic prev_arb = 1'b0;
	logic prev_req = 1'b0;
	logic in_flight = 1'b0; // accepted read awaiting its response
	logic [12:0] held_tag = '1; // tag of the read on the bus

	int ops[$];
	logic [63:0] va_q[$];
	logic [63:0] root_q[$];
	logic [63:0] pa_q[$];
	int kind_q[$];

	mem_model mem0 (.*);
	mmu_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic [63:0] table_word(input logic [63:0] addr);
		logic [63:0] w;
		w = '0;
		for (int i = 0; i < mem0.n_words; i++)
			if (mem0.word_addr[i] == addr)
				w = mem0.word_data[i];
		return w;
	endfunction

	// three levels, base + 8 * field, next base = ppn << 12
	task automatic check_walk_reads(input logic [63:0] va, input logic [63:0] root,
		input int first);
		logic [63:0] base;
		logic [63:0] addr;
		base = root;
		check("mem0.read_count", 64'(mem0.read_count - first), 64'd3);
		for (int lvl = 2; lvl >= 0; lvl--) begin
			addr = base + {52'd0, va[12 + 9 * lvl +: 9], 3'd0};
			check("bus_req", mem0.read_addr[(first + 2 - lvl) % 64], addr);
			base = (table_word(addr) >> 10) << 12;
		end
	endtask

	task automatic translate(input logic [63:0] va, input logic [63:0] root,
		input logic [63:0] pa, input int kind);
		int first;
		@(negedge clk);
		v_addr = va;
		ptbr = root;
		rd_signal = 1'b1;
		#10;
		first = mem0.read_count;
		if (kind == 1) begin
			check("addr_available", 64'(addr_available), 64'(mmu_pkg::st_miss));
			@(negedge clk);
			#10;
			check("addr_available", 64'(addr_available), 64'(mmu_pkg::st_waiting));
			while (addr_available == mmu_pkg::st_waiting) begin
				@(negedge clk);
				#10;
			end
			check_walk_reads(va, root, first);
		end
		check("addr_available", 64'(addr_available), 64'(mmu_pkg::st_hit));
		check("p_addr", p_addr, pa);
		@(negedge clk);
		rd_signal = 1'b0;
		#10;
		check("addr_available", 64'(addr_available), 64'(mmu_pkg::st_idle));
		check("p_addr", p_addr, 64'd0);
		if (kind == 0)
			check("mem0.read_count", 64'(mem0.read_count - first), 64'd0);
	endtask

	task automatic apply_reset();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#10;
		check("abtr_reqcyc", 64'(abtr_reqcyc), 64'd0);
		check("bus_reqcyc", 64'(bus_reqcyc), 64'd0);
		check("bus_respack", 64'(bus_respack), 64'd0);
		check("bus_busy", 64'(bus_busy), 64'd0);
		check("addr_available", 64'(addr_available), 64'(mmu_pkg::st_idle));
		check("p_addr", p_addr, 64'd0);
	endtask

	// bus handshake monitor just before each rising edge
	always @(negedge clk) begin
		#25;
		if (reset) begin
			prev_arb = 1'b0;
			prev_req = 1'b0;
			in_flight = 1'b0;
		end else begin
			if (prev_arb)
				check("abtr_reqcyc", 64'(abtr_reqcyc), 64'd1);
			if (prev_req)
				check("bus_reqcyc", 64'(bus_reqcyc), 64'd1);
			if (abtr_reqcyc || bus_reqcyc || in_flight)
				check("bus_busy", 64'(bus_busy), 64'd1);
			check("bus_respack", 64'(bus_respack),
				64'(bus_respcyc && bus_resptag == held_tag));
			if (bus_respcyc && bus_resptag == held_tag)
				in_flight = 1'b0;
			prev_arb = abtr_reqcyc && !abtr_grant;
			prev_req = bus_reqcyc && !bus_reqack;
			if (bus_reqcyc && bus_reqack) begin
				check("bus_reqtag changed", 64'(bus_reqtag != held_tag), 64'd1);
				held_tag = bus_reqtag;
				in_flight = 1'b1;
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (200 * n_req + 40) @(posedge clk);
		$display("timeout: translations not finished after %0d cycles", 200 * n_req + 40);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		string line;
		int fd;
		int n;
		int op;
		int kind;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		reset = 1'b1;
		rd_signal = 1'b0;
		v_addr = '0;
		ptbr = '0;
		fd = $fopen("test/mmu_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open test/mmu_vectors.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h", op, a, b, c, kind);
					if (op == 1) begin
						mem0.word_addr[mem0.n_words] = a;
						mem0.word_data[mem0.n_words] = b;
						mem0.n_words++;
					end else begin
						if (op == 2)
							n_req++;
						ops.push_back(op);
						va_q.push_back(a);
						root_q.push_back(b);
						pa_q.push_back(c);
						kind_q.push_back(kind);
					end
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
		apply_reset();
		foreach (ops[i]) begin
			if (ops[i] == 3) begin
				@(negedge clk);
				reset = 1'b1;
				rd_signal = 1'b0;
				apply_reset();
			end else
				translate(va_q[i], root_q[i], pa_q[i], kind_q[i]);
		end
		repeat (4) @(negedge clk);
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- vlog.f
verilog/mmu_pkg.sv
verilog/tlb.sv
verilog/page_walker.sv
verilog/bus_master.sv
verilog/mmu_top.sv
test/mem_model.sv
test/mmu_tb.sv

//--- run_sim.sh
#!/bin/bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	--top-module mmu_tb -f vlog.f -o mmu_sim &&
./obj_dir/mmu_sim | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- test/mmu_vectors.txt
# 1 addr data: page-table word in memory
# 2 v_addr ptbr p_addr kind: request, kind 0 = hit, 1 = walk
# 3: reset
1 10000 4801
1 10008 4401
1 12000 8c01
1 23028 8c00000006af340f
1 11010 8001
1 11020 8401
1 11030 8801
1 20018 2000040f
1 21018 2000080f
1 22018 20000c0f
2 ffffff8000005678 10000 300000001abcd678 1
2 ffffff8000005678 10000 300000001abcd678 0
2 ffffff8000005abc 10000 300000001abcdabc 0
2 40403123 10000 80001123 1
2 40803456 10000 80002456 1
2 40403777 10000 80001777 0
2 40c03010 10000 80003010 1
2 40403000 10000 80001000 0
2 40803456 10000 80002456 1
2 40c03ff8 10000 80003ff8 1
2 40803004 10000 80002004 0
3
2 ffffff8000005678 10000 300000001abcd678 1
2 40403123 10000 80001123 1
2 40403124 10000 80001124 0
